/* link_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////
// link side types
//////////////////////////////////////////////////

package link_pkg;

  // one word on the serial link streams
  typedef logic [31:0] word_t;

  // one memory burst, four link words wide
  typedef logic [127:0] burst_t;

  localparam int words_per_burst = 4;  // link words per burst

  // position of a word inside its burst, 0 is the least significant
  typedef logic [1:0] word_idx_t;

  //////////////////////////////////////////////////
  // pause synchronizer
  //////////////////////////////////////////////////

  // pause comes from the master fpga, async to clk125
  localparam int sync_stages_default = 2;  // flops in the pause chain

endpackage

`default_nettype wire

/* command_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////
// command and response word layout
//////////////////////////////////////////////////

package command_pkg;

  localparam int opcode_msb = 31;  // opcode / response code field
  localparam int opcode_lsb = 24;
  localparam int arg_width  = 24;  // argument in bits 23:0

  // opcodes from the master
  typedef enum logic [7:0] {
    op_echo      = 8'h01,  // answer with the argument
    op_read_fill = 8'h02   // answer, then stream memory data
  } opcode_t;

  // response codes to the master
  typedef enum logic [7:0] {
    resp_ack   = 8'h81,
    resp_fill  = 8'h82,
    resp_error = 8'hEE     // unknown opcode
  } resp_t;

  typedef enum logic [1:0] {st_idle, st_respond, st_fill} cmd_state_t;

endpackage

`default_nettype wire

/* word_stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// 32-bit word stream, valid/ready handshake with a last marker
interface word_stream_if;

  link_pkg::word_t data;   // payload word
  logic            valid;  // source has a word
  logic            last;   // final word of a packet
  logic            ready;  // sink takes the word

  // producer side
  modport source (
    output data, valid, last,
    input  ready
  );

  // consumer side
  modport sink (
    input  data, valid, last,
    output ready
  );

endinterface

`default_nettype wire

/* command_engine.sv */
`timescale 1ns/1ps
`default_nettype none

// command decoder for words from the link rx stream
// each command gets exactly one response word, a read_fill also
// hands the tx link to memory data until the fill's last word leaves
module command_engine (
  input  wire                  clk125,
  input  wire                  rst_n,
  input  wire link_pkg::word_t rx_data,
  input  wire                  rx_valid,
  output logic                 rx_ready,
  word_stream_if.source        tx,
  output logic                 use_mem_data,  // link granted to memory data
  input  wire                  fill_done      // last memory word went out
);

  command_pkg::cmd_state_t state;

  command_pkg::opcode_t opcode;     // opcode field of the incoming word
  command_pkg::resp_t   resp_code;  // decoded response code
  logic                 next_last;
  logic                 next_fill;

  link_pkg::word_t resp_word;  // held response, stable while valid
  logic            resp_last;
  logic            resp_fill;  // response opens a fill

  logic cmd_take;   // command word accepted
  logic resp_sent;  // response accepted by the link

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  always_comb begin
    opcode    = command_pkg::opcode_t'(rx_data[command_pkg::opcode_msb:command_pkg::opcode_lsb]);
    resp_code = command_pkg::resp_error;
    next_last = 1'b1;
    next_fill = 1'b0;
    case (opcode)
      command_pkg::op_echo: begin
        resp_code = command_pkg::resp_ack;
      end
      command_pkg::op_read_fill: begin
        resp_code = command_pkg::resp_fill;
        next_last = 1'b0;  // memory words follow
        next_fill = 1'b1;
      end
      default: begin
        resp_code = command_pkg::resp_error;  // low 24 bits echoed back
      end
    endcase
  end

  assign rx_ready  = (state == command_pkg::st_idle);  // one command at a time
  assign cmd_take  = rx_valid && rx_ready;
  assign resp_sent = tx.valid && tx.ready;

  // response payload, loaded with the command
  always_ff @(posedge clk125) begin
    if (cmd_take) begin
      resp_word <= {resp_code, rx_data[command_pkg::arg_width-1:0]};
      resp_last <= next_last;
      resp_fill <= next_fill;
    end
  end

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      state        <= command_pkg::st_idle;
      use_mem_data <= 1'b0;
    end else begin
      case (state)
        command_pkg::st_idle: begin
          if (cmd_take) state <= command_pkg::st_respond;
        end
        command_pkg::st_respond: begin
          if (resp_sent) begin
            if (resp_fill) begin
              state        <= command_pkg::st_fill;
              use_mem_data <= 1'b1;  // grant the link to memory
            end else begin
              state <= command_pkg::st_idle;
            end
          end
        end
        command_pkg::st_fill: begin
          if (fill_done) begin
            state        <= command_pkg::st_idle;
            use_mem_data <= 1'b0;  // back to command responses
          end
        end
        default: state <= command_pkg::st_idle;
      endcase
    end
  end

  // response stream
  assign tx.valid = (state == command_pkg::st_respond);
  assign tx.data  = resp_word;
  assign tx.last  = resp_last;

endmodule

`default_nettype wire

/* burst_width_converter.sv */
`timescale 1ns/1ps
`default_nettype none

// 128-bit burst to 32-bit word converter
// one burst is held at a time, words go out least significant first
module burst_width_converter (
  input  wire                   clk125,
  input  wire                   rst_n,
  input  wire link_pkg::burst_t burst_data,
  input  wire                   burst_valid,
  input  wire                   burst_last,   // final burst of the fill
  output logic                  burst_ready,
  word_stream_if.source         words
);

  localparam link_pkg::word_idx_t last_idx = link_pkg::word_idx_t'(link_pkg::words_per_burst - 1);
  localparam int word_bits = $bits(link_pkg::word_t);

  link_pkg::burst_t    burst_reg;  // held burst
  logic                last_reg;   // held burst closes the fill
  logic                held;       // holding register is full
  link_pkg::word_idx_t idx;        // word presented now

  logic burst_take;  // new burst accepted
  logic word_take;   // current word accepted downstream
  logic final_word;  // presenting word 3

  assign final_word = (idx == last_idx);
  assign word_take  = words.valid && words.ready;

  // refill while empty, or in the same cycle word 3 leaves
  assign burst_ready = !held || (word_take && final_word);
  assign burst_take  = burst_valid && burst_ready;

  //////////////////////////////////////////////////
  // holding register
  //////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (burst_take) begin
      burst_reg <= burst_data;
      last_reg  <= burst_last;
    end
  end

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      held <= 1'b0;
      idx  <= '0;
    end else if (burst_take) begin
      held <= 1'b1;  // next burst starts at word 0
      idx  <= '0;
    end else if (word_take) begin
      if (final_word) held <= 1'b0;  // burst drained
      idx <= idx + 1'b1;             // wraps to 0 after word 3
    end
  end

  // word output
  assign words.valid = held;
  assign words.data  = burst_reg[idx*word_bits +: word_bits];
  assign words.last  = last_reg && final_word;  // only the fill's last word

endmodule

`default_nettype wire

/* tx_stream_mux.sv */
`timescale 1ns/1ps
`default_nettype none

// 2:1 mux onto the link tx stream
// responses by default, memory words while use_mem_data is high
// no registers on the data path, only the pause synchronizer
module tx_stream_mux #(
  parameter int sync_stages = link_pkg::sync_stages_default
) (
  input  wire             clk125,
  input  wire             rst_n,
  input  wire             readout_pause,  // async level from the master
  input  wire             use_mem_data,   // select memory source
  word_stream_if.sink     cmd,            // command responses
  word_stream_if.sink     mem,            // memory words
  output link_pkg::word_t tx_data,
  output logic            tx_valid,
  output logic            tx_last,
  input  wire             tx_ready,
  output logic            fill_done       // last memory word taken
);

  logic [sync_stages-1:0] pause_sync;  // synchronizer chain
  logic                   pause_synced;
  logic                   link_open;   // link takes a word this cycle

  //////////////////////////////////////////////////
  // pause synchronizer
  //////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      pause_sync <= '0;
    end else begin
      pause_sync[0] <= readout_pause;
      for (int i = 1; i < sync_stages; i++) begin
        pause_sync[i] <= pause_sync[i-1];
      end
    end
  end

  assign pause_synced = pause_sync[sync_stages-1];
  assign link_open    = tx_ready && !pause_synced;

  //////////////////////////////////////////////////
  // source select
  //////////////////////////////////////////////////

  // valid held off during pause, data and last pass straight through
  assign tx_valid = (use_mem_data ? mem.valid : cmd.valid) && !pause_synced;
  assign tx_data  = use_mem_data ? mem.data : cmd.data;
  assign tx_last  = use_mem_data ? mem.last : cmd.last;

  // ready goes back to the active source only
  assign cmd.ready = !use_mem_data && link_open;
  assign mem.ready = use_mem_data && link_open;

  // end of fill tells the command engine to take the link back
  assign fill_done = mem.valid && mem.ready && mem.last;

endmodule

`default_nettype wire

/* channel_readout_top.sv */
`timescale 1ns/1ps
`default_nettype none

// readout path of one digitizer channel, all in clk125
module channel_readout_top #(
  parameter int sync_stages = link_pkg::sync_stages_default  // pause sync depth
) (
  input  wire                   clk125,
  input  wire                   rst_n,
  // link receive stream
  input  wire link_pkg::word_t  rx_data,
  input  wire                   rx_valid,
  input  wire                   rx_last,      // single-word commands, no framing needed
  output logic                  rx_ready,
  // memory bursts
  input  wire link_pkg::burst_t burst_data,
  input  wire                   burst_valid,
  input  wire                   burst_last,
  output logic                  burst_ready,
  // link transmit stream
  output link_pkg::word_t       tx_data,
  output logic                  tx_valid,
  output logic                  tx_last,
  input  wire                   tx_ready,
  input  wire                   readout_pause  // stop sending to the master
);

  word_stream_if cmd_stream ();  // responses to the mux
  word_stream_if mem_stream ();  // memory words to the mux

  logic use_mem_data;  // link granted to memory data
  logic fill_done;     // last memory word went out

  //////////////////////////////////////////////////
  // command side
  //////////////////////////////////////////////////

  command_engine u_command_engine (
    .clk125       (clk125),
    .rst_n        (rst_n),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .tx           (cmd_stream.source),
    .use_mem_data (use_mem_data),
    .fill_done    (fill_done)
  );

  // memory side, 128 to 32 bits
  burst_width_converter u_burst_width_converter (
    .clk125      (clk125),
    .rst_n       (rst_n),
    .burst_data  (burst_data),
    .burst_valid (burst_valid),
    .burst_last  (burst_last),
    .burst_ready (burst_ready),
    .words       (mem_stream.source)
  );

  //////////////////////////////////////////////////
  // tx mux
  //////////////////////////////////////////////////

  tx_stream_mux #(
    .sync_stages (sync_stages)
  ) u_tx_stream_mux (
    .clk125        (clk125),
    .rst_n         (rst_n),
    .readout_pause (readout_pause),
    .use_mem_data  (use_mem_data),
    .cmd           (cmd_stream.sink),
    .mem           (mem_stream.sink),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid),
    .tx_last       (tx_last),
    .tx_ready      (tx_ready),
    .fill_done     (fill_done)
  );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// clk125 source and power-on reset for the testbench
module tb_clock_gen #(
  parameter int half_period_ns = 4,   // 8 ns period
  parameter int reset_cycles   = 16   // rst_n low this many edges
) (
  output logic clk125,
  output logic rst_n
);

  initial begin
    clk125 = 1'b0;
    forever #(half_period_ns) clk125 = ~clk125;
  end

  // release lands on a rising edge like every other driven input
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk125);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* channel_readout_props.sv */
`timescale 1ns/1ps
`default_nettype none

// link side protocol checks bound into tx_stream_mux
module channel_readout_props #(
  parameter int sync_stages = link_pkg::sync_stages_default  // pause chain depth
) (
  input wire                  clk125,
  input wire                  rst_n,
  input wire                  readout_pause,  // raw pause at the mux input
  input wire link_pkg::word_t tx_data,
  input wire                  tx_valid,
  input wire                  tx_last,
  input wire                  tx_ready,
  input wire                  cmd_ready,    // ready back to the command engine
  input wire                  mem_ready,    // ready back to the converter
  input wire                  pause_synced  // pause after the sync chain
);

  // a stalled word holds still, pause is the only thing allowed to pull valid
  tx_hold_a: assert property (
    @(posedge clk125) disable iff (!rst_n)
      (tx_valid && !tx_ready) |=>
        (pause_synced || (tx_valid && $stable(tx_data) && $stable(tx_last)))
  ) else $error("tx word or last changed while stalled");

  // only the selected source ever sees ready
  one_ready_a: assert property (
    @(posedge clk125) disable iff (!rst_n)
      !(cmd_ready && mem_ready)
  ) else $error("both source readies high");

  // pause sampled sync_stages edges back has reached the end of the chain
  pause_quiet_a: assert property (
    @(posedge clk125) disable iff (!rst_n)
      $past(readout_pause, sync_stages) |-> !tx_valid
  ) else $error("tx_valid high after the pause passed the synchronizer");

endmodule

`default_nettype wire

/* channel_readout_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the channel readout path
// all traffic comes from the stimulus file
module channel_readout_tb;

  localparam int stim_depth     = 64;  // record slots in the file image
  localparam int reset_cycles   = 16;
  localparam int cycles_per_rec = 40;  // watchdog budget per stimulus line
  localparam logic [3:0] kind_none   = 4'h0;  // unused slot
  localparam logic [3:0] kind_cmd    = 4'h1;
  localparam logic [3:0] kind_burst  = 4'h2;
  localparam logic [3:0] kind_pause  = 4'h3;
  localparam logic [3:0] kind_expect = 4'h4;

  logic clk125, rst_n;
  link_pkg::word_t  rx_data, tx_data;
  link_pkg::burst_t burst_data;
  logic rx_valid, rx_last, rx_ready, burst_valid, burst_last, burst_ready;
  logic tx_valid, tx_last, tx_ready, readout_pause;

  logic [135:0]     stim_mem [0:stim_depth-1];  // kind, flag, 128-bit payload
  link_pkg::word_t  cmd_q[$], exp_word_q[$];
  link_pkg::burst_t burst_q[$];
  logic             burst_last_q[$], exp_last_q[$];
  int unsigned      pause_delay_q[$], pause_len_q[$];
  int               exp_test_q[$];
  int               n_records = 0, n_expected = 0, seen_count = 0;
  logic             loaded = 1'b0, cmds_done = 1'b0, bursts_done = 1'b0;

  tb_clock_gen #(.reset_cycles(reset_cycles)) u_clock (.clk125(clk125), .rst_n(rst_n));

  channel_readout_top u_channel_readout_top (
    .clk125 (clk125), .rst_n (rst_n),
    .rx_data (rx_data), .rx_valid (rx_valid), .rx_last (rx_last), .rx_ready (rx_ready),
    .burst_data (burst_data), .burst_valid (burst_valid),
    .burst_last (burst_last), .burst_ready (burst_ready),
    .tx_data (tx_data), .tx_valid (tx_valid), .tx_last (tx_last), .tx_ready (tx_ready),
    .readout_pause (readout_pause)
  );

  bind tx_stream_mux channel_readout_props #(.sync_stages (sync_stages)) u_props (
    .clk125 (clk125), .rst_n (rst_n), .readout_pause (readout_pause),
    .tx_data (tx_data), .tx_valid (tx_valid),
    .tx_last (tx_last), .tx_ready (tx_ready), .cmd_ready (cmd.ready),
    .mem_ready (mem.ready), .pause_synced (pause_synced)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  function automatic string test_name(input int id);
    case (id)
      1: return "echo";
      2: return "bad_opcode";
      3: return "read_fill";
      4: return "cmd_during_fill";
      5: return "fill_with_pause";
      6: return "opcode_zero";
      7: return "echo_after_fill";
      default: return "unnamed";
    endcase
  endfunction

  ////////////////////////////////////////////////
  // stimulus file
  ////////////////////////////////////////////////

  task automatic load_stimulus();
    logic [3:0]   kind;
    logic [127:0] payload;
    for (int i = 0; i < stim_depth; i++) begin
      stim_mem[i] = {8'h00, 128'(i)};  // kind 0 marks slots the file leaves alone
    end
    $readmemh("channel_readout_stimulus.txt", stim_mem);
    for (int i = 0; i < stim_depth; i++) begin
      kind    = stim_mem[i][135:132];
      payload = stim_mem[i][127:0];
      if (kind !== kind_none) begin
        n_records++;
        case (kind)
          kind_cmd:   cmd_q.push_back(payload[31:0]);
          kind_burst: begin
            burst_q.push_back(payload);
            burst_last_q.push_back(stim_mem[i][128]);
          end
          kind_pause: begin
            pause_delay_q.push_back(payload[63:32]);  // idle cycles before the window
            pause_len_q.push_back(payload[31:0]);
          end
          kind_expect: begin
            exp_word_q.push_back(payload[31:0]);
            exp_last_q.push_back(stim_mem[i][128]);
            exp_test_q.push_back(int'(payload[39:32]));
          end
          default: report_failure($sformatf("stimulus slot %0d has unknown kind %h", i, kind));
        endcase
      end
    end
    n_expected = exp_word_q.size();
  endtask

  ////////////////////////////////////////////////
  // drivers on rising edges
  ////////////////////////////////////////////////

  task automatic wait_for_reset();
    @(posedge clk125);
    while (!rst_n) @(posedge clk125);
  endtask

  task automatic drive_commands();
    logic taken;
    wait_for_reset();
    while (cmd_q.size() > 0) begin
      rx_data  <= cmd_q.pop_front();
      rx_valid <= 1'b1;
      rx_last  <= 1'b1;  // every command is one word
      do begin
        @(negedge clk125);
        taken = rx_ready;  // transfer on the coming edge
        @(posedge clk125);
      end while (!taken);
    end
    rx_valid  <= 1'b0;
    cmds_done = 1'b1;
  endtask

  task automatic drive_bursts();
    logic taken;
    wait_for_reset();
    while (burst_q.size() > 0) begin
      burst_data  <= burst_q.pop_front();
      burst_last  <= burst_last_q.pop_front();
      burst_valid <= 1'b1;
      do begin
        @(negedge clk125);
        taken = burst_ready;
        @(posedge clk125);
      end while (!taken);
    end
    burst_valid <= 1'b0;
    bursts_done = 1'b1;
  endtask

  task automatic link_cycle(input logic pause);
    tx_ready      <= ($urandom % 4) != 0;  // low about a quarter of the time
    readout_pause <= pause;
    @(posedge clk125);
  endtask

  // pause windows follow each other, counted from the end of reset
  task automatic drive_link();
    wait_for_reset();
    for (int w = 0; w < pause_delay_q.size(); w++) begin
      repeat (pause_delay_q[w]) link_cycle(1'b0);
      repeat (pause_len_q[w]) link_cycle(1'b1);
    end
    forever link_cycle(1'b0);
  endtask

  task automatic run_watchdog(input int unsigned limit_cycles);
    repeat (limit_cycles) @(posedge clk125);
    report_failure($sformatf("timeout: run timed out after %0d cycles, %0d of %0d words seen",
                             limit_cycles, seen_count, n_expected));
  endtask

  // idle outputs in the first cycle out of reset, before any input moves
  task automatic check_reset_state();
    @(posedge rst_n);
    @(negedge clk125);
    assert (rx_ready === 1'b1)
      else report_failure($sformatf("mismatch in reset_state: expected rx_ready 1, actual %b",
                                    rx_ready));
    assert (burst_ready === 1'b1)
      else report_failure($sformatf("mismatch in reset_state: expected burst_ready 1, actual %b",
                                    burst_ready));
    assert (tx_valid === 1'b0)
      else report_failure($sformatf("mismatch in reset_state: expected tx_valid 0, actual %b",
                                    tx_valid));
  endtask

  ////////////////////////////////////////////////
  // tx monitor sampled mid-cycle
  ////////////////////////////////////////////////

  task automatic check_tx_word();
    link_pkg::word_t exp_word;
    logic            exp_last;
    int              test_id;
    assert (exp_word_q.size() > 0)
      else report_failure($sformatf("tx sent word %h after the expected list ran out", tx_data));
    exp_word = exp_word_q.pop_front();
    exp_last = exp_last_q.pop_front();
    test_id  = exp_test_q.pop_front();
    assert ({tx_last, tx_data} === {exp_last, exp_word})
      else report_failure($sformatf("mismatch in %s: expected %h last %0b, actual %h last %0b",
                                    test_name(test_id), exp_word, exp_last, tx_data, tx_last));
    seen_count++;
  endtask

  always @(negedge clk125) begin
    if (loaded && rst_n && tx_valid && tx_ready) begin
      check_tx_word();  // this word goes out on the next edge
    end
  end

  initial begin
    void'($urandom(32'h48eb_e539));  // single seed for the whole run
    rx_data       = '0;
    rx_valid      = 1'b0;
    rx_last       = 1'b0;
    burst_data    = '0;
    burst_valid   = 1'b0;
    burst_last    = 1'b0;
    tx_ready      = 1'b0;
    readout_pause = 1'b0;
    load_stimulus();
    loaded = 1'b1;
    fork
      drive_commands();
      drive_bursts();
      drive_link();
      run_watchdog(reset_cycles + cycles_per_rec * n_records);
    join_none
    check_reset_state();
    wait (cmds_done && bursts_done && seen_count == n_expected);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* channel_readout_stimulus.txt */
// columns: kind _ flag _ 128-bit payload in hex, kind 1 command, 2 burst (flag burst_last)
// kind 3 pause (bits 63:32 delay, 31:0 length), kind 4 expected tx word (flag tx_last)
// kind 4 payload: bits 39:32 test id, bits 31:0 word

// commands, sent in order
1_0_00000000_00000000_00000000_0100a5c3
1_0_00000000_00000000_00000000_7f123456
1_0_00000000_00000000_00000000_02000010
1_0_00000000_00000000_00000000_0100beef
1_0_00000000_00000000_00000000_02000020
1_0_00000000_00000000_00000000_00abcdef
1_0_00000000_00000000_00000000_01fedcba

// bursts, loaded as soon as the converter has room
2_0_10000003_10000002_10000001_10000000
2_1_20000003_20000002_20000001_20000000
2_1_3000000d_3000000c_3000000b_3000000a

// pause windows, delay from the previous window then length
3_0_00000000_00000000_00000018_0000000c
3_0_00000000_00000000_00000014_00000010

// expected tx words
4_1_00000000_00000000_00000001_8100a5c3
4_1_00000000_00000000_00000002_ee123456
4_0_00000000_00000000_00000003_82000010
4_0_00000000_00000000_00000003_10000000
4_0_00000000_00000000_00000003_10000001
4_0_00000000_00000000_00000003_10000002
4_0_00000000_00000000_00000003_10000003
4_0_00000000_00000000_00000003_20000000
4_0_00000000_00000000_00000003_20000001
4_0_00000000_00000000_00000003_20000002
4_1_00000000_00000000_00000003_20000003
4_1_00000000_00000000_00000004_8100beef
4_0_00000000_00000000_00000005_82000020
4_0_00000000_00000000_00000005_3000000a
4_0_00000000_00000000_00000005_3000000b
4_0_00000000_00000000_00000005_3000000c
4_1_00000000_00000000_00000005_3000000d
4_1_00000000_00000000_00000006_eeabcdef
4_1_00000000_00000000_00000007_81fedcba

/* flist.f */
link_pkg.sv
command_pkg.sv
word_stream_if.sv
command_engine.sv
burst_width_converter.sv
tx_stream_mux.sv
channel_readout_top.sv
tb_clock_gen.sv
channel_readout_props.sv
channel_readout_tb.sv
